// ==== project.f ====
hdl/routerPkg.sv
hdl/packetTimer.sv
hdl/switchArbiter.sv
hdl/outputStage.sv
hdl/routerArbiterTop.sv
sim/routerArbiterSva.sv
sim/tbRouterArbiter.sv

// ==== run.sh ====
#!/bin/sh
# Builds the router arbiter testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f \
  --top-module tbRouterArbiter \
  -Mdir obj_dir -o simRouterArbiter
status=$?
if [ "$status" -ne 0 ]; then
  echo "run.sh: Verilator build returned status $status"
  exit "$status"
fi

./obj_dir/simRouterArbiter
status=$?
if [ "$status" -ne 0 ]; then
  echo "run.sh: testbench run returned status $status"
  exit "$status"
fi

exit 0

// ==== sim/tbRouterArbiter.sv ====
`timescale 1ns/1ps

module tbRouterArbiter;

  localparam int plannedCycles = 2400;
  localparam int timeoutCycles = plannedCycles + plannedCycles / 4;
  localparam int randomCycles  = 2200;

  localparam routerPkg::flitIdT bodyId = 3'd2;

  typedef routerPkg::flitT [routerPkg::portCount-1:0] flitVecT;

  // Expected top level outputs after the next edge.
  typedef struct packed {
    routerPkg::portVecT grant;
    routerPkg::flitT    flit;
    logic               valid;
  } expT;

  logic               clk = 1'b0;
  logic               rst;
  flitVecT            inFlit;
  routerPkg::portVecT req;
  routerPkg::portVecT grant;
  routerPkg::flitT    outFlit;
  logic               outValid;

  logic [31:0]        lcgState = 32'h9e6fafc5;
  int                 cycleCount;
  int                 modelState;
  routerPkg::lengthT  modelLen [routerPkg::portCount];
  routerPkg::lengthT  modelCount [routerPkg::portCount];
  expT                expOut;

  routerArbiterTop dut
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .req      (req),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // First requester in rotation after the given port or -1.
  function automatic int rotateFrom(input routerPkg::portVecT reqs, input int after);
    int result;
    int idx;
    result = -1;
    for (int k = 1; k <= routerPkg::portCount; k++)
    begin
      idx = (after + k) % routerPkg::portCount;
      if (result < 0 && reqs[idx])
      begin
        result = idx;
      end
    end
    return result;
  endfunction

  // Advances the model by one edge with the inputs sampled there.
  function automatic expT refStep(input routerPkg::portVecT reqs, input flitVecT flits);
    expT                result;
    routerPkg::portVecT runBits;
    int                 after;
    int                 nextState;
    result  = '0;
    runBits = '0;
    if (modelState >= 0)
    begin
      result.flit  = flits[modelState];
      result.valid = 1'b1;
    end
    // Idle searches from Local.
    after = (modelState >= 0) ? modelState : routerPkg::portCount - 1;
    if (modelState >= 0 && reqs[modelState] && modelCount[modelState] != modelLen[modelState])
    begin
      runBits[modelState] = 1'b1;
      nextState = modelState;
    end
    else
    begin
      nextState = rotateFrom(reqs, after);
    end
    for (int p = 0; p < routerPkg::portCount; p++)
    begin
      if (flits[p].flitId == routerPkg::flitHeader)
      begin
        modelLen[p] = flits[p].payload[$bits(routerPkg::lengthT)-1:0];
      end
      modelCount[p] = runBits[p] ? modelCount[p] + 1'b1 : '0;
    end
    modelState = nextState;
    if (nextState >= 0)
    begin
      result.grant[nextState] = 1'b1;
    end
    return result;
  endfunction

  // Same identifier on all ports and a 3-bit length per port in the low payload bits.
  function automatic flitVecT makeFlits(input routerPkg::flitIdT id, input logic [14:0] lens);
    flitVecT flits;
    for (int p = 0; p < routerPkg::portCount; p++)
    begin
      flits[p].flitId  = id;
      flits[p].payload = {4'(p), 9'd0, lens[3*p +: 3]};
    end
    return flits;
  endfunction

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic driveInputs(input routerPkg::portVecT reqs, input flitVecT flits);
    @(posedge clk);
    req    <= reqs;
    inFlit <= flits;
  endtask

  task automatic holdCycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic driveRandom();
    logic [31:0]        r;
    routerPkg::portVecT reqs;
    flitVecT            flits;
    r    = lcgNext();
    reqs = r[31:27] | r[26:22];
    for (int p = 0; p < routerPkg::portCount; p++)
    begin
      r = lcgNext();
      flits[p].flitId = r[31:29];
      if (r[31:29] == routerPkg::flitHeader)
      begin
        flits[p].payload = {r[28:25], 9'd0, r[18:16]};
      end
      else
      begin
        flits[p].payload = r[28:13];
      end
    end
    driveInputs(reqs, flits);
  endtask

  // Counts consecutive granted cycles of one port at falling edges.
  task automatic checkTenure(input int port, input int expected);
    int held;
    held = 0;
    @(negedge clk);
    while (!grant[port])
    begin
      @(negedge clk);
    end
    while (grant[port])
    begin
      held++;
      @(negedge clk);
    end
    assert (held == expected)
    else stopOnError($sformatf("error: %0t ns port %0d held the grant %0d cycles, expected %0d",
                               $time, port, held, expected));
  endtask

  always @(negedge clk)
  begin
    if (rst)
    begin
      modelState = -1;
      for (int p = 0; p < routerPkg::portCount; p++)
      begin
        modelLen[p]   = '0;
        modelCount[p] = '0;
      end
      expOut     = '0;
      cycleCount = 0;
    end
    else
    begin
      cycleCount++;
      if (cycleCount >= timeoutCycles)
      begin
        stopOnError($sformatf("timeout: tests still running after %0d cycles", cycleCount));
      end
      assert (grant == expOut.grant)
      else stopOnError($sformatf("error: %0t ns grant %b, expected %b",
                                 $time, grant, expOut.grant));
      assert (outValid == expOut.valid)
      else stopOnError($sformatf("error: %0t ns outValid %b, expected %b",
                                 $time, outValid, expOut.valid));
      assert (outFlit == expOut.flit)
      else stopOnError($sformatf("error: %0t ns outFlit %h, expected %h",
                                 $time, outFlit, expOut.flit));
      expOut = refStep(req, inFlit);
    end
  end

  initial
  begin
    rst    = 1'b1;
    req    = '0;
    inFlit = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Idle after reset.
    holdCycles(4);

    // North alone with length 3 while body flits carry another length.
    driveInputs('0, makeFlits(routerPkg::flitHeader, {3'd0, 3'd0, 3'd0, 3'd3, 3'd0}));
    driveInputs(5'b00010, makeFlits(bodyId, {5{3'd7}}));
    holdCycles(14);
    driveInputs('0, makeFlits(bodyId, '0));
    holdCycles(2);

    // Rotation with West silent and then all five ports.
    driveInputs('0, makeFlits(routerPkg::flitHeader, {3'd2, 3'd0, 3'd3, 3'd1, 3'd2}));
    driveInputs(5'b10111, makeFlits(bodyId, {5{3'd7}}));
    checkTenure(0, 3);
    holdCycles(20);
    driveInputs(5'b11111, makeFlits(bodyId, {5{3'd7}}));
    holdCycles(24);
    driveInputs('0, makeFlits(bodyId, '0));
    holdCycles(2);

    // Holder drops its request before timeout.
    driveInputs('0, makeFlits(routerPkg::flitHeader, {5{3'd7}}));
    driveInputs(5'b00101, makeFlits(bodyId, '0));
    holdCycles(3);
    driveInputs(5'b00100, makeFlits(bodyId, '0));
    holdCycles(4);
    driveInputs('0, makeFlits(bodyId, '0));
    holdCycles(3);

    // South length 5 survives body flits of another identifier.
    driveInputs('0, makeFlits(routerPkg::flitHeader, {3'd5, 3'd0, 3'd0, 3'd0, 3'd0}));
    driveInputs(5'b10001, makeFlits(3'd3, {5{3'd1}}));
    checkTenure(4, 6);
    holdCycles(10);
    driveInputs('0, makeFlits(3'd3, '0));
    holdCycles(2);

    // Long random run.
    repeat (randomCycles) driveRandom();
    driveInputs('0, '0);
    holdCycles(3);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== sim/routerArbiterSva.sv ====
`timescale 1ns/1ps

module routerArbiterSva
(
  input logic                clk,
  input logic                rst,
  input routerPkg::portVecT  req,
  input routerPkg::portVecT  grant,
  input routerPkg::portVecT  timesUp,
  input routerPkg::arbStateT state
);

  routerPkg::portVecT expiring;

  // Holder whose timer ran out while still requesting.
  assign expiring = grant & timesUp & req;

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set: %b", grant);

  grantClearAfterReset: assert property (@(posedge clk)
    rst |=> ((state == routerPkg::idle) && (grant == '0)))
    else $error("arbiter not idle after reset: state %b grant %b", state, grant);

  // Another waiting port takes over from an expired holder.
  yieldOnTimeout: assert property (@(posedge clk) disable iff (rst)
    ((expiring != '0) && ((req & ~grant) != '0)) |=> ((grant & $past(expiring)) == '0))
    else $error("expired holder kept the grant: %b", grant);

  // A sole requester is granted again.
  soleRequesterKeeps: assert property (@(posedge clk) disable iff (rst)
    ((expiring != '0) && ((req & ~grant) == '0)) |=> (grant == $past(grant)))
    else $error("sole requester lost the grant: %b", grant);

endmodule

bind switchArbiter routerArbiterSva arbiterChecks
(
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .grant   (grant),
  .timesUp (timesUp),
  .state   (state)
);

// ==== hdl/routerArbiterTop.sv ====
`timescale 1ns/1ps

module routerArbiterTop
(
  input  logic                                         clk,
  input  logic                                         rst,
  input  routerPkg::flitT [routerPkg::portCount-1:0] inFlit,
  input  routerPkg::portVecT                           req,
  output routerPkg::portVecT                           grant,
  output routerPkg::flitT                              outFlit,
  output logic                                         outValid
);

  // Grant decision, registered.
  switchArbiter arbiter
  (
    .clk    (clk),
    .rst    (rst),
    .inFlit (inFlit),
    .req    (req),
    .grant  (grant)
  );

  // Output link register, one cycle behind the grant.
  outputStage outStage
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .inFlit   (inFlit),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// ==== hdl/outputStage.sv ====
`timescale 1ns/1ps

module outputStage
(
  input  logic                                         clk,
  input  logic                                         rst,
  input  routerPkg::portVecT                           grant,
  input  routerPkg::flitT [routerPkg::portCount-1:0] inFlit,
  output routerPkg::flitT                              outFlit,
  output logic                                         outValid
);

  routerPkg::flitT selFlit;
  logic            anyGrant;

  // Grant is one-hot, so an OR of the masked flits is the mux.
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < routerPkg::portCount; p++)
    begin
      if (grant[p])
      begin
        selFlit = selFlit | inFlit[p];
      end
    end
  end

  assign anyGrant = |grant;

  // One register stage onto the output link.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= selFlit;
      outValid <= anyGrant;
    end
  end

endmodule

// ==== hdl/switchArbiter.sv ====
`timescale 1ns/1ps

module switchArbiter
(
  input  logic                                         clk,
  input  logic                                         rst,
  input  routerPkg::flitT [routerPkg::portCount-1:0] inFlit,
  input  routerPkg::portVecT                           req,
  output routerPkg::portVecT                           grant
);

  routerPkg::arbStateT state;
  routerPkg::arbStateT nextState;
  routerPkg::portVecT  run;
  routerPkg::portVecT  timesUp;

  // One tenure timer per input port.
  for (genvar p = 0; p < routerPkg::portCount; p++)
  begin : genTimer
    packetTimer timerInst
    (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlit[p]),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  // Grant state for a port index.
  function automatic routerPkg::arbStateT stateOf(input int idx);
    routerPkg::arbStateT result;
    case (idx)
      0:       result = routerPkg::grantLocal;
      1:       result = routerPkg::grantNorth;
      2:       result = routerPkg::grantEast;
      3:       result = routerPkg::grantWest;
      4:       result = routerPkg::grantSouth;
      default: result = routerPkg::idle;
    endcase
    return result;
  endfunction

  // Port index held in a grant state.
  // Idle maps to South so that the search starts at Local.
  function automatic int holderOf(input routerPkg::arbStateT st);
    int result;
    case (st)
      routerPkg::grantLocal: result = 0;
      routerPkg::grantNorth: result = 1;
      routerPkg::grantEast:  result = 2;
      routerPkg::grantWest:  result = 3;
      default:               result = routerPkg::portCount - 1;
    endcase
    return result;
  endfunction

  // First requester in rotation after the given port.
  // The given port itself is checked last.
  function automatic routerPkg::arbStateT pickNext
  (
    input routerPkg::portVecT reqs,
    input int                 after
  );
    routerPkg::arbStateT result;
    int                  idx;
    result = routerPkg::idle;
    for (int k = routerPkg::portCount; k >= 1; k--)
    begin
      idx = after + k;
      if (idx >= routerPkg::portCount)
      begin
        idx = idx - routerPkg::portCount;
      end
      if (reqs[idx])
      begin
        result = stateOf(idx);
      end
    end
    return result;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    int holder;
    holder    = holderOf(state);
    run       = '0;
    nextState = routerPkg::idle;
    case (state)
      routerPkg::idle:
      begin
        nextState = pickNext(req, holder);
      end
      routerPkg::grantLocal,
      routerPkg::grantNorth,
      routerPkg::grantEast,
      routerPkg::grantWest,
      routerPkg::grantSouth:
      begin
        // Holder keeps the link until it drops out or its timer expires.
        if (req[holder] && !timesUp[holder])
        begin
          run[holder] = 1'b1;
          nextState   = state;
        end
        else
        begin
          nextState = pickNext(req, holder);
        end
      end
      default:
      begin
        nextState = routerPkg::idle;
      end
    endcase
  end

  // Grant bits are the state without the idle bit.
  assign grant = state[routerPkg::portCount:1];

endmodule

// ==== hdl/packetTimer.sv ====
`timescale 1ns/1ps

module packetTimer
(
  input  logic           clk,
  input  logic           rst,
  input  routerPkg::flitT inFlit,
  input  logic           run,
  output logic           timesUp
);

  routerPkg::lengthT lengthReg;
  routerPkg::lengthT count;
  logic              isHeader;

  assign isHeader = (inFlit.flitId == routerPkg::flitHeader);

  // Length is only taken from header flits.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lengthReg <= '0;
    end
    else if (isHeader)
    begin
      lengthReg <= inFlit.payload[$bits(routerPkg::lengthT)-1:0];
    end
  end

  // Counts granted cycles, restarts whenever the port is not running.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesUp = (count == lengthReg);

endmodule

// ==== hdl/routerPkg.sv ====
package routerPkg;

  // Local, North, East, West, South.
  localparam int portCount = 5;

  typedef logic [2:0] flitIdT;

  // Identifier of the first flit of a packet.
  localparam flitIdT flitHeader = 3'd1;

  // Tenure in clock cycles, carried in the header payload.
  typedef logic [11:0] lengthT;

  typedef logic [15:0] payloadT;

  typedef struct packed {
    flitIdT  flitId;
    payloadT payload;
  } flitT;

  // One bit per port, Local in bit 0.
  typedef logic [portCount-1:0] portVecT;

  // One-hot arbiter states.
  typedef enum logic [5:0] {
    idle       = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } arbStateT;

endpackage
